//--- common/axi_slave_pkg.sv
// Shared widths, burst and response enums, channel structs and request checking for the AXI slave
package axi_slave_pkg;

  //////////////////// widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;   // byte lanes per beat
  localparam int ID_W      = 4;
  localparam int LEN_W     = 4;   // beats minus one
  localparam int MEM_BYTES = 128; // starts at or above this decode to no slave
  localparam int MEM_WORDS = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [2:0]        size_t;
  typedef logic [4:0]        word_t;

  localparam size_t      MAX_SIZE = 3'd2;  // 4 bytes per beat
  localparam logic [7:0] MEM_INIT = 8'h0C;

  typedef enum logic [1:0] {FIXED = 2'd0, INCR = 2'd1, WRAP = 2'd2} burst_e;
  typedef enum logic [1:0] {OKAY = 2'd0, SLVERR = 2'd2, DECERR = 2'd3} resp_e;

  //////////////////// channel payloads
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } ax_req_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_beat_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_resp_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_beat_t;

  typedef struct packed {
    word_t word;
    data_t data;
    strb_t strb;
  } mem_wr_t;

  // slave errors take priority over decode errors
  function automatic resp_e check_request(ax_req_t req);
    logic [ADDR_W:0] bytes;
    logic [ADDR_W:0] aligned;
    logic [ADDR_W:0] last_byte;
    logic            wrap_len_ok;
    bytes       = (ADDR_W+1)'(1) << req.size;
    aligned     = {1'b0, req.addr} & ~(bytes - 1'b1);
    last_byte   = aligned + (((ADDR_W+1)'(req.len) + 1'b1) << req.size) - 1'b1;
    wrap_len_ok = req.len inside {4'd1, 4'd3, 4'd7, 4'd15};
    if (req.size > MAX_SIZE) begin
      return SLVERR;
    end else if (req.burst == WRAP && (!wrap_len_ok || {1'b0, req.addr} != aligned)) begin
      return SLVERR;
    end else if (req.addr >= MEM_BYTES) begin
      return DECERR;
    end else if (req.burst == INCR && last_byte >= MEM_BYTES) begin
      return DECERR;
    end
    return OKAY;
  endfunction

endpackage

//--- hw/axi_addr_gen.sv
// Burst address generator; loaded with a request, then stepped once per beat by its path
`timescale 1ns/100ps

module axi_addr_gen (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   load,
  input  axi_slave_pkg::ax_req_t req,
  input  logic                   advance,
  output axi_slave_pkg::addr_t   addr
);

  axi_slave_pkg::addr_t  addr_q;
  axi_slave_pkg::size_t  size_q;
  axi_slave_pkg::burst_e burst_q;
  axi_slave_pkg::addr_t  boundary_q;  // total bytes of the burst
  axi_slave_pkg::addr_t  bytes;
  axi_slave_pkg::addr_t  step_addr;
  axi_slave_pkg::addr_t  next_addr;

  //////////////////// next beat address
  always_comb begin
    bytes     = axi_slave_pkg::addr_t'(1) << size_q;
    step_addr = (addr_q & ~(bytes - 1'b1)) + bytes;  // next size-aligned address
    case (burst_q)
      axi_slave_pkg::INCR: next_addr = step_addr;
      axi_slave_pkg::WRAP: begin
        // crossing the boundary folds back to the start of the wrap window
        if ((step_addr & (boundary_q - 1'b1)) == '0) begin
          next_addr = step_addr - boundary_q;
        end else begin
          next_addr = step_addr;
        end
      end
      default: next_addr = addr_q;  // fixed
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      addr_q     <= '0;
      size_q     <= '0;
      burst_q    <= axi_slave_pkg::FIXED;
      boundary_q <= '0;
    end else if (load) begin
      addr_q     <= req.addr;
      size_q     <= req.size;
      burst_q    <= req.burst;
      boundary_q <= (axi_slave_pkg::addr_t'(req.len) + 1'b1) << req.size;
    end else if (advance) begin
      addr_q <= next_addr;
    end
  end

  assign addr = addr_q;

  a_load_advance_excl : assert property (@(posedge clk) disable iff (!resetn)
    !(load && advance));

endmodule

//--- hw/axi_byte_mem.sv
// 128-byte slave memory as 32 words of byte lanes; strobed write port, combinational read port
`timescale 1ns/100ps

module axi_byte_mem (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   wr_en,
  input  axi_slave_pkg::mem_wr_t wr,
  input  axi_slave_pkg::word_t   rd_word,
  output axi_slave_pkg::data_t   rd_data
);

  // each word is a packed array of byte lanes, lane i is byte i of the word
  logic [axi_slave_pkg::STRB_W-1:0][7:0] mem_q [axi_slave_pkg::MEM_WORDS];

  //////////////////// write port
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int w = 0; w < axi_slave_pkg::MEM_WORDS; w++) begin
        mem_q[w] <= {axi_slave_pkg::STRB_W{axi_slave_pkg::MEM_INIT}};
      end
    end else if (wr_en) begin
      for (int i = 0; i < axi_slave_pkg::STRB_W; i++) begin
        if (wr.strb[i]) begin
          mem_q[wr.word][i] <= wr.data[8*i +: 8];  // only strobed lanes change
        end
      end
    end
  end

  //////////////////// read port
  // old contents are seen when the same word is written in this cycle
  assign rd_data = mem_q[rd_word];

endmodule

//--- hw/axi_write_path/axi_write_path.sv
// Write side of the AXI slave; AW/W/B channel FSM that turns accepted beats into memory writes
`timescale 1ns/100ps

module axi_write_path (
  input  logic                    clk,
  input  logic                    resetn,
  // write address
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axi_slave_pkg::ax_req_t  aw,
  // write data
  input  logic                    w_valid,
  output logic                    w_ready,
  input  axi_slave_pkg::w_beat_t  w,
  // write response
  output logic                    b_valid,
  input  logic                    b_ready,
  output axi_slave_pkg::b_resp_t  b,
  // address generator
  output logic                    gen_load,
  output axi_slave_pkg::ax_req_t  gen_req,
  output logic                    gen_advance,
  input  axi_slave_pkg::addr_t    beat_addr,
  // memory
  output logic                    mem_wr_en,
  output axi_slave_pkg::mem_wr_t  mem_wr
);

  typedef enum logic [1:0] {ST_ADDR, ST_DATA, ST_RESP} state_e;

  state_e                 state;
  axi_slave_pkg::ax_req_t req_q;
  axi_slave_pkg::resp_e   resp_q;
  axi_slave_pkg::len_t    beat_cnt;
  logic                   aw_hs;
  logic                   w_hs;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;

  //////////////////// channel FSM
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= ST_ADDR;
      aw_ready <= 1'b1;
      w_ready  <= 1'b0;
      b_valid  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_ADDR: begin
          if (!aw_ready) begin
            aw_ready <= 1'b1;  // reopens one cycle after the response
          end else if (aw_valid) begin
            aw_ready <= 1'b0;
            beat_cnt <= '0;
            state    <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (!w_ready) begin
            w_ready <= 1'b1;
          end else if (w_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (w.last) begin
              w_ready <= 1'b0;
              b_valid <= 1'b1;
              state   <= ST_RESP;
            end
          end
        end
        ST_RESP: begin
          if (b_ready) begin  // held until the master takes it
            b_valid <= 1'b0;
            state   <= ST_ADDR;
          end
        end
        default: state <= ST_ADDR;
      endcase
    end
  end

  // request and its verdict, judged once per burst
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      req_q  <= aw;
      resp_q <= axi_slave_pkg::check_request(aw);
    end
  end

  //////////////////// generator and memory
  assign gen_load    = aw_hs;
  assign gen_req     = aw;
  assign gen_advance = w_hs;

  assign mem_wr_en   = w_hs && (resp_q == axi_slave_pkg::OKAY);  // error bursts are drained
  assign mem_wr.word = beat_addr[$clog2(axi_slave_pkg::MEM_BYTES)-1:$clog2(axi_slave_pkg::STRB_W)];
  assign mem_wr.data = w.data;
  assign mem_wr.strb = w.strb;

  assign b.id   = req_q.id;
  assign b.resp = resp_q;

  a_last_on_final_beat : assert property (@(posedge clk) disable iff (!resetn)
    w_hs |-> (w.last == (beat_cnt == req_q.len)));

  a_b_stable : assert property (@(posedge clk) disable iff (!resetn)
    b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

//--- hw/axi_read_path/axi_read_path.sv
// Read side of the AXI slave; AR/R channel FSM with a registered R beat kept one address ahead
`timescale 1ns/100ps

module axi_read_path (
  input  logic                    clk,
  input  logic                    resetn,
  // read address
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  axi_slave_pkg::ax_req_t  ar,
  // read data
  output logic                    r_valid,
  input  logic                    r_ready,
  output axi_slave_pkg::r_beat_t  r,
  // address generator
  output logic                    gen_load,
  output axi_slave_pkg::ax_req_t  gen_req,
  output logic                    gen_advance,
  input  axi_slave_pkg::addr_t    beat_addr,
  // memory
  output axi_slave_pkg::word_t    mem_rd_word,
  input  axi_slave_pkg::data_t    mem_rd_data
);

  typedef enum logic {ST_ADDR, ST_DATA} state_e;

  state_e                 state;
  axi_slave_pkg::ax_req_t req_q;
  axi_slave_pkg::resp_e   resp_q;
  axi_slave_pkg::len_t    beat_cnt;  // index of the beat held in r_q
  axi_slave_pkg::len_t    next_cnt;
  axi_slave_pkg::r_beat_t r_q;
  logic                   ar_hs;
  logic                   load_beat;

  assign ar_hs = ar_valid && ar_ready;

  // first fill when the register is empty, then one refill per accepted non-last beat
  assign load_beat = (state == ST_DATA) && (!r_valid || (r_ready && !r_q.last));
  assign next_cnt  = r_valid ? beat_cnt + 1'b1 : '0;

  //////////////////// channel FSM
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= ST_ADDR;
      ar_ready <= 1'b1;
      r_valid  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_ADDR: begin
          if (!ar_ready) begin
            ar_ready <= 1'b1;
          end else if (ar_valid) begin
            ar_ready <= 1'b0;
            state    <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (load_beat) begin
            r_valid  <= 1'b1;
            beat_cnt <= next_cnt;
          end else if (r_ready) begin
            r_valid <= 1'b0;  // last beat accepted
            state   <= ST_ADDR;
          end
        end
        default: state <= ST_ADDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      req_q  <= ar;
      resp_q <= axi_slave_pkg::check_request(ar);
    end
  end

  //////////////////// R beat register
  always_ff @(posedge clk) begin
    if (load_beat) begin
      r_q.id   <= req_q.id;
      r_q.data <= (resp_q == axi_slave_pkg::OKAY) ? mem_rd_data : '0;
      r_q.resp <= resp_q;
      r_q.last <= (next_cnt == req_q.len);
    end
  end

  assign r = r_q;

  // generator stays one beat ahead of the register
  assign gen_load    = ar_hs;
  assign gen_req     = ar;
  assign gen_advance = load_beat;
  assign mem_rd_word = beat_addr[$clog2(axi_slave_pkg::MEM_BYTES)-1:$clog2(axi_slave_pkg::STRB_W)];

  a_r_stable : assert property (@(posedge clk) disable iff (!resetn)
    r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

//--- hw/axi_slave_top.sv
// Top of the AXI3 memory slave; connects both channel paths, their address generators and memory
`timescale 1ns/100ps

module axi_slave_top (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axi_slave_pkg::ax_req_t  aw,
  input  logic                    w_valid,
  output logic                    w_ready,
  input  axi_slave_pkg::w_beat_t  w,
  output logic                    b_valid,
  input  logic                    b_ready,
  output axi_slave_pkg::b_resp_t  b,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  axi_slave_pkg::ax_req_t  ar,
  output logic                    r_valid,
  input  logic                    r_ready,
  output axi_slave_pkg::r_beat_t  r
);

  logic                   wr_gen_load;
  logic                   wr_gen_advance;
  axi_slave_pkg::ax_req_t wr_gen_req;
  axi_slave_pkg::addr_t   wr_beat_addr;
  logic                   rd_gen_load;
  logic                   rd_gen_advance;
  axi_slave_pkg::ax_req_t rd_gen_req;
  axi_slave_pkg::addr_t   rd_beat_addr;
  logic                   mem_wr_en;
  axi_slave_pkg::mem_wr_t mem_wr;
  axi_slave_pkg::word_t   mem_rd_word;
  axi_slave_pkg::data_t   mem_rd_data;

  //////////////////// write side
  axi_write_path u_write_path (
    .clk, .resetn, .aw_valid, .aw_ready, .aw, .w_valid, .w_ready, .w,
    .b_valid, .b_ready, .b,
    .gen_load (wr_gen_load), .gen_req (wr_gen_req), .gen_advance (wr_gen_advance),
    .beat_addr (wr_beat_addr), .mem_wr_en, .mem_wr
  );

  axi_addr_gen u_wr_gen (
    .clk, .resetn, .load (wr_gen_load), .req (wr_gen_req), .advance (wr_gen_advance),
    .addr (wr_beat_addr)
  );

  //////////////////// read side
  axi_read_path u_read_path (
    .clk, .resetn, .ar_valid, .ar_ready, .ar, .r_valid, .r_ready, .r,
    .gen_load (rd_gen_load), .gen_req (rd_gen_req), .gen_advance (rd_gen_advance),
    .beat_addr (rd_beat_addr), .mem_rd_word, .mem_rd_data
  );

  axi_addr_gen u_rd_gen (
    .clk, .resetn, .load (rd_gen_load), .req (rd_gen_req), .advance (rd_gen_advance),
    .addr (rd_beat_addr)
  );

  axi_byte_mem u_mem (
    .clk, .resetn, .wr_en (mem_wr_en), .wr (mem_wr), .rd_word (mem_rd_word),
    .rd_data (mem_rd_data)
  );

endmodule

//--- dv/axi_slave_tests.svh
// Burst driver tasks and directed tests, included inside the testbench top module

//////////////////// burst drivers
task automatic write_burst(input axi_slave_pkg::ax_req_t req,
    input axi_slave_pkg::data_t data [$], input axi_slave_pkg::strb_t strb [$],
    input axi_slave_pkg::resp_e exp_resp);
  axi_slave_pkg::w_beat_t beat;
  axi_slave_pkg::b_resp_t exp_b;
  axi_slave_pkg::addr_t   a;
  int                     gap;
  @(posedge clk);
  aw_valid <= 1'b1;
  aw       <= req;
  wait_for("aw_ready");
  @(posedge clk);  // AW handshake
  aw_valid <= 1'b0;
  for (int k = 0; k <= req.len; k++) begin
    beat.data = data[k];
    beat.strb = strb[k];
    beat.last = (k == req.len);
    w_valid <= 1'b1;
    w       <= beat;
    wait_for("w_ready");
    @(posedge clk);  // beat accepted here
  end
  w_valid <= 1'b0;
  exp_b.id   = req.id;
  exp_b.resp = exp_resp;
  wait_for("b_valid");
  expect_low("w_ready", w_ready);
  gap = bp ? $unsigned($random(seed)) % 6 : 0;
  repeat (gap) begin
    check_b(exp_b);  // must hold while stalled
    expect_low("aw_ready", aw_ready);
    @(negedge clk);
  end
  check_b(exp_b);
  expect_low("aw_ready", aw_ready);  // pending B blocks the next AW
  @(posedge clk);
  b_ready <= 1'b1;
  @(posedge clk);
  b_ready <= 1'b0;
  if (exp_resp == axi_slave_pkg::OKAY) begin
    for (int k = 0; k <= req.len; k++) begin
      a = beat_addr(req, k);
      for (int i = 0; i < 4; i++) begin
        if (strb[k][i]) begin
          model[{a[6:2], 2'b00} + i] = data[k][8*i +: 8];
        end
      end
    end
  end
endtask

task automatic write_random(input axi_slave_pkg::ax_req_t req,
    input axi_slave_pkg::resp_e exp_resp);
  axi_slave_pkg::data_t d [$];
  axi_slave_pkg::strb_t s [$];
  repeat (int'(req.len) + 1) begin
    d.push_back($random(seed));
    s.push_back(4'hF);
  end
  write_burst(req, d, s, exp_resp);
endtask

task automatic read_burst(input axi_slave_pkg::ax_req_t req,
    input axi_slave_pkg::resp_e exp_resp);
  axi_slave_pkg::r_beat_t exp_r;
  int                     gap;
  @(posedge clk);
  ar_valid <= 1'b1;
  ar       <= req;
  wait_for("ar_ready");
  @(posedge clk);
  ar_valid <= 1'b0;
  for (int k = 0; k <= req.len; k++) begin
    exp_r.id   = req.id;
    exp_r.data = (exp_resp == axi_slave_pkg::OKAY) ? model_word(beat_addr(req, k)) : '0;
    exp_r.resp = exp_resp;
    exp_r.last = (k == req.len);
    wait_for("r_valid");
    expect_low("ar_ready", ar_ready);
    gap = bp ? $unsigned($random(seed)) % 6 : 0;
    repeat (gap) begin
      check_r(exp_r);
      @(negedge clk);
    end
    check_r(exp_r);
    @(posedge clk);
    r_ready <= 1'b1;
    @(posedge clk);  // R handshake
    r_ready <= 1'b0;
  end
  @(negedge clk);
  if (r_valid) begin
    err_count++;
    $display("R channel kept r_valid high after the last beat at %0t", $time);
  end
endtask

//////////////////// directed tests
task automatic read_reset_contents();
  int e0;
  e0 = err_count;
  read_burst(make_req(4'h3, 32'h0, 4'd3, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::OKAY);
  report_test("reset contents", e0);
endtask

task automatic incr_write_read();
  int e0;
  e0 = err_count;
  write_random(make_req(4'h1, 32'h40, 4'd7, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::OKAY);
  read_burst(make_req(4'h2, 32'h40, 4'd7, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::OKAY);
  report_test("incr write and read-back", e0);
endtask

task automatic fixed_strobe_merge();
  axi_slave_pkg::data_t d [$];
  axi_slave_pkg::strb_t s [$];
  int                   e0;
  e0 = err_count;
  repeat (3) d.push_back($random(seed));
  s = '{4'b0001, 4'b0110, 4'b1000};
  write_burst(make_req(4'h4, 32'h10, 4'd2, 3'd2, axi_slave_pkg::FIXED), d, s,
              axi_slave_pkg::OKAY);
  read_burst(make_req(4'h5, 32'h10, 4'd1, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::OKAY);
  report_test("fixed burst with partial strobes", e0);
endtask

task automatic wrap_write_read();
  int e0;
  e0 = err_count;
  write_random(make_req(4'h6, 32'h28, 4'd3, 3'd2, axi_slave_pkg::WRAP), axi_slave_pkg::OKAY);
  read_burst(make_req(4'h7, 32'h20, 4'd3, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::OKAY);
  read_burst(make_req(4'h8, 32'h28, 4'd3, 3'd2, axi_slave_pkg::WRAP), axi_slave_pkg::OKAY);
  report_test("wrap addressing", e0);
endtask

task automatic error_responses();
  int e0;
  e0 = err_count;
  write_random(make_req(4'h9, 32'h0, 4'd0, 3'd3, axi_slave_pkg::INCR), axi_slave_pkg::SLVERR);
  read_burst(make_req(4'h9, 32'h0, 4'd1, 3'd3, axi_slave_pkg::INCR), axi_slave_pkg::SLVERR);
  write_random(make_req(4'hA, 32'h80, 4'd0, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::DECERR);
  read_burst(make_req(4'hA, 32'h80, 4'd2, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::DECERR);
  write_random(make_req(4'hB, 32'h7C, 4'd1, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::DECERR);
  write_random(make_req(4'hC, 32'h0, 4'd2, 3'd2, axi_slave_pkg::WRAP), axi_slave_pkg::SLVERR);
  // nothing above may have reached the memory
  read_burst(make_req(4'hD, 32'h78, 4'd1, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::OKAY);
  read_burst(make_req(4'hE, 32'h0, 4'd3, 3'd2, axi_slave_pkg::INCR), axi_slave_pkg::OKAY);
  report_test("error responses", e0);
endtask

//--- dv/axi_slave_tb.sv
// Testbench top for the AXI slave; runs the directed tests against a byte model and reports
`timescale 1ns/100ps

module axi_slave_tb;

  localparam int TIMEOUT = 200;  // cycles allowed for any single wait

  logic                   clk;
  logic                   resetn;
  logic                   aw_valid;
  logic                   aw_ready;
  axi_slave_pkg::ax_req_t aw;
  logic                   w_valid;
  logic                   w_ready;
  axi_slave_pkg::w_beat_t w;
  logic                   b_valid;
  logic                   b_ready;
  axi_slave_pkg::b_resp_t b;
  logic                   ar_valid;
  logic                   ar_ready;
  axi_slave_pkg::ax_req_t ar;
  logic                   r_valid;
  logic                   r_ready;
  axi_slave_pkg::r_beat_t r;

  logic [7:0] model [128];  // expected memory bytes
  integer     seed;
  int         err_count;
  int         tests_run;
  int         tests_failed;
  bit         bp;           // random ready gaps on B and R
  bit         timed_out;

  axi_slave_top DUT (.*);

  always #4 clk = ~clk;

  //////////////////// helpers
  function automatic axi_slave_pkg::ax_req_t make_req(input axi_slave_pkg::id_t id,
      input axi_slave_pkg::addr_t addr, input axi_slave_pkg::len_t len,
      input axi_slave_pkg::size_t size, input axi_slave_pkg::burst_e burst);
    axi_slave_pkg::ax_req_t req;
    req.id    = id;
    req.addr  = addr;
    req.len   = len;
    req.size  = size;
    req.burst = burst;
    return req;
  endfunction

  // byte address of beat k, straight from the burst rules
  function automatic axi_slave_pkg::addr_t beat_addr(input axi_slave_pkg::ax_req_t req,
      input int k);
    axi_slave_pkg::addr_t bytes;
    axi_slave_pkg::addr_t span;
    axi_slave_pkg::addr_t base;
    bytes = 32'd1 << req.size;
    span  = (32'(req.len) + 1) * bytes;
    base  = req.addr - (req.addr % span);
    case (req.burst)
      axi_slave_pkg::FIXED: return req.addr;
      axi_slave_pkg::INCR:  return (k == 0) ? req.addr : req.addr - (req.addr % bytes) + k * bytes;
      default:              return base + ((req.addr - base + k * bytes) % span);
    endcase
  endfunction

  function automatic axi_slave_pkg::data_t model_word(input axi_slave_pkg::addr_t a);
    int b0;
    b0 = {a[6:2], 2'b00};
    return {model[b0+3], model[b0+2], model[b0+1], model[b0]};
  endfunction

  function automatic logic chan_up(input string what);
    case (what)
      "aw_ready": return aw_ready;
      "w_ready":  return w_ready;
      "b_valid":  return b_valid;
      "ar_ready": return ar_ready;
      default:    return r_valid;
    endcase
  endfunction

  task automatic finish_run();
    $display("summary: %0d tests, %0d failing, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic wait_for(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("%s never went high within %0d cycles, the channel is stuck", what, TIMEOUT);
        timed_out = 1'b1;
        finish_run();
      end
    end while (!chan_up(what));
  endtask

  //////////////////// compare tasks
  task automatic check_b(input axi_slave_pkg::b_resp_t exp);
    if (!b_valid || b !== exp) begin
      err_count++;
      $display("[ERROR] %0t: B valid %b id %h resp %0d, expected id %h resp %0d",
               $time, b_valid, b.id, b.resp, exp.id, exp.resp);
    end
  endtask

  task automatic check_r(input axi_slave_pkg::r_beat_t exp);
    if (!r_valid || r !== exp) begin
      err_count++;
      $display("[ERROR] %0t: R valid %b id %h data %h resp %0d last %b, expected %h %h %0d %b",
               $time, r_valid, r.id, r.data, r.resp, r.last,
               exp.id, exp.data, exp.resp, exp.last);
    end
  endtask

  task automatic expect_low(input string name, input logic level);
    if (level !== 1'b0) begin
      err_count++;
      $display("[ERROR] %0t: %s is %b while a burst is still open", $time, name, level);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("%s%s: PASS", name, bp ? " under back-pressure" : "");
    end else begin
      tests_failed++;
      $display("%s%s: FAIL", name, bp ? " under back-pressure" : "");
    end
  endtask

  `include "axi_slave_tests.svh"

  //////////////////// sequence
  initial begin
    clk          = 1'b0;
    resetn       = 1'b0;
    aw_valid     = 1'b0;
    aw           = '0;
    w_valid      = 1'b0;
    w            = '0;
    b_ready      = 1'b0;
    ar_valid     = 1'b0;
    ar           = '0;
    r_ready      = 1'b0;
    seed         = 32'h73e96063;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    bp           = 1'b0;
    timed_out    = 1'b0;
    for (int i = 0; i < 128; i++) begin
      model[i] = 8'h0C;
    end
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    read_reset_contents();
    incr_write_read();
    fixed_strobe_merge();
    wrap_write_read();
    error_responses();
    bp = 1'b1;
    incr_write_read();
    wrap_write_read();
    finish_run();
  end

endmodule

//--- filelist.f
+incdir+dv
common/axi_slave_pkg.sv
hw/axi_addr_gen.sv
hw/axi_byte_mem.sv
hw/axi_write_path/axi_write_path.sv
hw/axi_read_path/axi_read_path.sv
hw/axi_slave_top.sv
dv/axi_slave_tb.sv
